// File: cacc_regfile.f
+incdir+.
csb_pkg.sv
cacc_reg_pkg.sv
cacc_csb_bridge.sv
cacc_single_reg.sv
cacc_dual_reg.sv
cacc_group_ctrl.sv
cacc_regfile.sv
tb_cacc_regfile.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the cacc register file testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --top-module tb_cacc_regfile -f cacc_regfile.f \
  --Mdir obj_dir -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation passed"

// File: tb_cacc_regfile.sv
/*
 * testbench for the cacc register file
 * random csb traffic and done pulses, checked against a cycle model
 */
`default_nettype none
`include "cacc_consts.svh"

module tb_cacc_regfile;
  import cacc_reg_pkg::*;

  localparam int CLK_PERIOD    = 8;
  localparam int TEST_CYCLES   = 200 + 100 + 200 + 200 + 400 + 4;
  localparam int WATCHDOG_TIME = (TEST_CYCLES + 8 + 50) * CLK_PERIOD;

  logic                     nvdla_core_clk;
  logic                     nvdla_core_rstn;
  logic                     csb2cacc_req_pvld;
  logic [`CACC_REQ_W-1:0]   csb2cacc_req_pd;
  logic                     dp2reg_done;
  logic [`CACC_DATA_W-1:0]  dp2reg_sat_count;
  logic                     csb2cacc_req_prdy;
  logic                     cacc2csb_resp_valid;
  logic [`CACC_RESP_W-1:0]  cacc2csb_resp_pd;
  logic                     reg2dp_op_en;
  conv_mode_e               reg2dp_conv_mode;
  precision_e               reg2dp_proc_precision;
  logic [`CACC_SIZE_W-1:0]  reg2dp_dataout_width;
  logic [`CACC_SIZE_W-1:0]  reg2dp_dataout_height;
  logic [`CACC_DATA_W-1:0]  reg2dp_dataout_addr;

  //////////////////////////////
  // reference model state
  //////////////////////////////
  logic                        m_producer;
  logic                        m_consumer;
  logic                        m_op_en [2];
  logic                        m_mode [2];
  logic [1:0]                  m_prec [2];
  logic [`CACC_SIZE_W-1:0]     m_width [2];
  logic [`CACC_SIZE_W-1:0]     m_height [2];
  logic [`CACC_DATA_W-1:0]     m_addr [2];
  logic [`CACC_DATA_W-1:0]     m_sat [2];
  logic [`CACC_OPEN_DELAY-1:0] m_dly;
  logic                        m_req_v;   // request stage ahead of the response
  logic [`CACC_REQ_W-1:0]      m_req_pd;
  logic                        m_resp_v;
  logic [`CACC_RESP_W-1:0]     m_resp_pd;

  logic checking;
  int   checks;
  int   errors;

  cacc_regfile i_dut (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .csb2cacc_req_pvld     (csb2cacc_req_pvld),
    .csb2cacc_req_pd       (csb2cacc_req_pd),
    .dp2reg_done           (dp2reg_done),
    .dp2reg_sat_count      (dp2reg_sat_count),
    .csb2cacc_req_prdy     (csb2cacc_req_prdy),
    .cacc2csb_resp_valid   (cacc2csb_resp_valid),
    .cacc2csb_resp_pd      (cacc2csb_resp_pd),
    .reg2dp_op_en          (reg2dp_op_en),
    .reg2dp_conv_mode      (reg2dp_conv_mode),
    .reg2dp_proc_precision (reg2dp_proc_precision),
    .reg2dp_dataout_width  (reg2dp_dataout_width),
    .reg2dp_dataout_height (reg2dp_dataout_height),
    .reg2dp_dataout_addr   (reg2dp_dataout_addr)
  );

  initial nvdla_core_clk = 1'b0;
  always #(CLK_PERIOD / 2) nvdla_core_clk = ~nvdla_core_clk;

  task automatic model_reset();
    m_producer = 1'b0;
    m_consumer = 1'b0;
    for (int k = 0; k < 2; k++) begin
      m_op_en[k]  = 1'b0;
      m_mode[k]   = 1'b0;
      m_prec[k]   = '0;
      m_width[k]  = '0;
      m_height[k] = '0;
      m_addr[k]   = '0;
      m_sat[k]    = '0;
    end
    m_dly     = '0;
    m_req_v   = 1'b0;
    m_req_pd  = '0;
    m_resp_v  = 1'b0;
    m_resp_pd = '0;
  endtask

  // idle / running / pending as the host sees it
  function automatic logic [1:0] group_status(input logic kb);
    if (!m_op_en[kb]) return GRP_IDLE;
    else if (m_consumer == kb) return GRP_RUNNING;
    else return GRP_PENDING;
  endfunction

  function automatic logic [31:0] model_read(input logic [11:0] offs);
    logic [31:0] d;
    logic        g;
    d = '0;
    g = m_producer;  // host reads the group it programs
    case (offs)
      `CACC_OFFS_POINTER: begin
        d[0]  = m_producer;
        d[16] = m_consumer;
      end
      `CACC_OFFS_STATUS: begin
        d[1:0]   = group_status(1'b0);
        d[17:16] = group_status(1'b1);
      end
      `CACC_OFFS_OP_ENABLE:     d[0] = m_op_en[g];
      `CACC_OFFS_MISC_CFG: begin
        d[0]     = m_mode[g];
        d[13:12] = m_prec[g];
      end
      `CACC_OFFS_DATAOUT_SIZE:  d = {3'b0, m_height[g], 3'b0, m_width[g]};
      `CACC_OFFS_DATAOUT_ADDR:  d = m_addr[g];
      `CACC_OFFS_SAT_COUNT:     d = m_sat[g];
      default: d = '0;  // unmapped
    endcase
    return d;
  endfunction

  // one clock edge of the model using the inputs held over the last cycle
  task automatic model_edge();
    logic [11:0] offs;
    logic [31:0] wdata;
    logic        is_wr;
    logic        rd_en;
    logic        wr_en;
    logic        c;
    logic        kb;
    logic        wr_g;
    logic        done_g;
    logic        op_next;
    offs  = {m_req_pd[9:0], 2'b00};
    wdata = m_req_pd[53:22];
    is_wr = m_req_pd[`CACC_REQ_WRITE_BIT];
    rd_en = m_req_v & ~is_wr;
    wr_en = m_req_v & is_wr;
    c     = m_consumer;
    // response register takes read data from the old state
    m_resp_v = rd_en | (wr_en & m_req_pd[`CACC_REQ_NPOSTED_BIT]);
    if (m_resp_v) begin
      m_resp_pd = '0;
      m_resp_pd[`CACC_RESP_KIND_BIT] = is_wr;
      if (rd_en) m_resp_pd[31:0] = model_read(offs);
    end
    if (dp2reg_done) m_dly = '0;  // flushed on done
    else m_dly = {m_dly[`CACC_OPEN_DELAY-2:0], m_op_en[c]};
    for (int k = 0; k < 2; k++) begin
      kb      = (k == 1);
      wr_g    = wr_en && offs >= `CACC_DUAL_BASE && m_producer == kb && !m_op_en[k];
      done_g  = dp2reg_done && c == kb;
      op_next = m_op_en[k];
      if (wr_g && offs == `CACC_OFFS_OP_ENABLE) op_next = wdata[0];
      else if (done_g) op_next = 1'b0;
      if (m_op_en[k] && !op_next) m_sat[k] = dp2reg_sat_count;
      else if (!m_op_en[k] && op_next) m_sat[k] = '0;
      m_op_en[k] = op_next;
      if (wr_g && offs == `CACC_OFFS_MISC_CFG) begin
        m_mode[k] = wdata[0];
        m_prec[k] = wdata[13:12];
      end
      if (wr_g && offs == `CACC_OFFS_DATAOUT_SIZE) begin
        m_width[k]  = wdata[`CACC_SIZE_W-1:0];
        m_height[k] = wdata[16 +: `CACC_SIZE_W];
      end
      if (wr_g && offs == `CACC_OFFS_DATAOUT_ADDR) m_addr[k] = wdata;
    end
    if (wr_en && offs == `CACC_OFFS_POINTER) m_producer = wdata[0];
    if (dp2reg_done) m_consumer = ~m_consumer;
    m_req_v = csb2cacc_req_pvld;
    if (csb2cacc_req_pvld) m_req_pd = csb2cacc_req_pd;
  endtask

  task automatic report_mismatch(input string what, input logic [63:0] got,
                                 input logic [63:0] exp);
    errors++;
    $display("Fail %0t: %s got %0h expected %0h", $time, what, got, exp);
  endtask

  // outputs are settled mid cycle
  always @(negedge nvdla_core_clk) begin
    if (checking) begin
      checks += 8;
      if (csb2cacc_req_prdy !== 1'b1)
        report_mismatch("req_prdy", 64'(csb2cacc_req_prdy), 64'd1);
      if (cacc2csb_resp_valid !== m_resp_v)
        report_mismatch("resp_valid", 64'(cacc2csb_resp_valid), 64'(m_resp_v));
      if (m_resp_v && cacc2csb_resp_pd !== m_resp_pd)
        report_mismatch("resp_pd", 64'(cacc2csb_resp_pd), 64'(m_resp_pd));
      if (reg2dp_op_en !== m_dly[`CACC_OPEN_DELAY-1])
        report_mismatch("reg2dp_op_en", 64'(reg2dp_op_en), 64'(m_dly[`CACC_OPEN_DELAY-1]));
      if (reg2dp_conv_mode !== m_mode[m_consumer])
        report_mismatch("conv_mode", 64'(reg2dp_conv_mode), 64'(m_mode[m_consumer]));
      if (reg2dp_proc_precision !== m_prec[m_consumer])
        report_mismatch("precision", 64'(reg2dp_proc_precision), 64'(m_prec[m_consumer]));
      if ({reg2dp_dataout_height, reg2dp_dataout_width} !==
          {m_height[m_consumer], m_width[m_consumer]})
        report_mismatch("dataout_size", 64'({reg2dp_dataout_height, reg2dp_dataout_width}),
                        64'({m_height[m_consumer], m_width[m_consumer]}));
      if (reg2dp_dataout_addr !== m_addr[m_consumer])
        report_mismatch("dataout_addr", 64'(reg2dp_dataout_addr), 64'(m_addr[m_consumer]));
    end
  end

  function automatic logic [11:0] pick_write_offs(input logic [31:0] r);
    case (r % 6)
      0: return `CACC_OFFS_POINTER;
      1: return `CACC_OFFS_MISC_CFG;
      2: return `CACC_OFFS_DATAOUT_SIZE;
      3: return `CACC_OFFS_DATAOUT_ADDR;
      4: return `CACC_OFFS_SAT_COUNT;  // read only so the write is lost
      default: return {1'b1, r[18:10], 2'b00};
    endcase
  endfunction

  function automatic logic [11:0] pick_read_offs(input logic [31:0] r);
    if (r % 9 == 8) return {1'b1, r[18:10], 2'b00};
    else return {7'b0, r[2:0], 2'b00};  // 0x000 up to 0x01c
  endfunction

  // new inputs for one cycle with upper address and spare bits left random
  task automatic drive_random(input int wr_pct, input int op_pct, input int done_pct);
    logic [31:0]            r;
    logic [`CACC_REQ_W-1:0] pd;
    logic [11:0]            offs;
    logic                   is_wr;
    r     = $urandom;
    pd    = {r[30:0], $urandom};
    is_wr = ($urandom % 100) < wr_pct;
    if (is_wr && ($urandom % 100) < op_pct) offs = `CACC_OFFS_OP_ENABLE;
    else if (is_wr) offs = pick_write_offs($urandom);
    else offs = pick_read_offs($urandom);
    pd[9:0] = offs[11:2];
    pd[`CACC_REQ_WRITE_BIT] = is_wr;
    csb2cacc_req_pvld = ($urandom % 100) < 70;
    csb2cacc_req_pd   = pd;
    dp2reg_done       = ($urandom % 100) < done_pct;
    dp2reg_sat_count  = $urandom;
  endtask

  task automatic run_test(input string name, input int ncyc, input int wr_pct,
                          input int op_pct, input int done_pct);
    int err_start;
    err_start = errors;
    for (int i = 0; i < ncyc; i++) begin
      @(posedge nvdla_core_clk);
      model_edge();
      #1;
      drive_random(wr_pct, op_pct, done_pct);
    end
    $display("test %s finished: %0d cycles, %0d errors", name, ncyc, errors - err_start);
  endtask

  // idle inputs until the requests in flight have answered
  task automatic drain_requests(input int ncyc);
    int err_start;
    err_start = errors;
    for (int i = 0; i < ncyc; i++) begin
      @(posedge nvdla_core_clk);
      model_edge();
      #1;
      csb2cacc_req_pvld = 1'b0;
      dp2reg_done       = 1'b0;
    end
    @(negedge nvdla_core_clk);
    #1;  // checker has seen the last edge
    $display("test drain finished: %0d cycles, %0d errors", ncyc, errors - err_start);
  endtask

  initial begin
    void'($urandom(60973));
    checking          = 1'b0;
    checks            = 0;
    errors            = 0;
    nvdla_core_rstn   = 1'b0;
    csb2cacc_req_pvld = 1'b0;
    csb2cacc_req_pd   = '0;
    dp2reg_done       = 1'b0;
    dp2reg_sat_count  = '0;
    model_reset();
    repeat (8) @(posedge nvdla_core_clk);
    #1;
    nvdla_core_rstn = 1'b1;
    checking        = 1'b1;
    run_test("field_access", 200, 50, 0, 0);
    run_test("write_response", 100, 80, 0, 0);
    run_test("op_en_protect", 200, 60, 40, 0);
    run_test("done_pulse", 200, 50, 30, 15);
    run_test("random_mix", 400, 50, 20, 5);
    // let the last requests drain
    drain_requests(4);
    checking = 1'b0;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("watchdog expired, the run did not finish in %0d time units", WATCHDOG_TIME);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: cacc_regfile.sv
/*
 * cacc register file top
 * csb bridge, single group, two ping-pong groups, group controller
 */
`default_nettype none
`include "cacc_consts.svh"

module cacc_regfile (
  input  wire                         nvdla_core_clk,
  input  wire                         nvdla_core_rstn,
  input  wire                         csb2cacc_req_pvld,
  input  wire  [`CACC_REQ_W-1:0]      csb2cacc_req_pd,
  input  wire                         dp2reg_done,
  input  wire  [`CACC_DATA_W-1:0]     dp2reg_sat_count,
  output logic                        csb2cacc_req_prdy,
  output logic                        cacc2csb_resp_valid,
  output logic [`CACC_RESP_W-1:0]     cacc2csb_resp_pd,
  output logic                        reg2dp_op_en,
  output cacc_reg_pkg::conv_mode_e    reg2dp_conv_mode,
  output cacc_reg_pkg::precision_e    reg2dp_proc_precision,
  output logic [`CACC_SIZE_W-1:0]     reg2dp_dataout_width,
  output logic [`CACC_SIZE_W-1:0]     reg2dp_dataout_height,
  output logic [`CACC_DATA_W-1:0]     reg2dp_dataout_addr
);
  import cacc_reg_pkg::*;

  // bridge side
  logic [`CACC_OFFS_W-1:0] reg_offset;
  logic [`CACC_DATA_W-1:0] reg_wr_data;
  logic                    reg_wr_en;
  logic [`CACC_DATA_W-1:0] reg_rd_data;

  // group side
  logic                    s_wr_en;
  logic                    d0_wr_en;
  logic                    d1_wr_en;
  logic [`CACC_DATA_W-1:0] s_rd_data;
  logic [`CACC_DATA_W-1:0] d0_rd_data;
  logic [`CACC_DATA_W-1:0] d1_rd_data;
  logic                    d0_done;
  logic                    d1_done;
  logic                    d0_op_en;
  logic                    d1_op_en;
  logic                    producer;
  logic                    consumer;
  group_status_e           status_0;
  group_status_e           status_1;

  // per group fields
  conv_mode_e              d0_conv_mode;
  conv_mode_e              d1_conv_mode;
  precision_e              d0_proc_precision;
  precision_e              d1_proc_precision;
  logic [`CACC_SIZE_W-1:0] d0_dataout_width;
  logic [`CACC_SIZE_W-1:0] d1_dataout_width;
  logic [`CACC_SIZE_W-1:0] d0_dataout_height;
  logic [`CACC_SIZE_W-1:0] d1_dataout_height;
  logic [`CACC_DATA_W-1:0] d0_dataout_addr;
  logic [`CACC_DATA_W-1:0] d1_dataout_addr;

  cacc_csb_bridge u_csb_bridge (
    .nvdla_core_clk      (nvdla_core_clk),
    .nvdla_core_rstn     (nvdla_core_rstn),
    .csb2cacc_req_pvld   (csb2cacc_req_pvld),
    .csb2cacc_req_pd     (csb2cacc_req_pd),
    .reg_rd_data         (reg_rd_data),
    .csb2cacc_req_prdy   (csb2cacc_req_prdy),
    .cacc2csb_resp_valid (cacc2csb_resp_valid),
    .cacc2csb_resp_pd    (cacc2csb_resp_pd),
    .reg_offset          (reg_offset),
    .reg_wr_data         (reg_wr_data),
    .reg_wr_en           (reg_wr_en),
    .reg_rd_en           ()  // reads need no strobe, the mux is combinational
  );

  cacc_single_reg u_single_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data),
    .reg_wr_en       (s_wr_en),
    .consumer        (consumer),
    .status_0        (status_0),
    .status_1        (status_1),
    .reg_rd_data     (s_rd_data),
    .producer        (producer)
  );

  cacc_dual_reg u_dual_reg_d0 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data),
    .reg_wr_en       (d0_wr_en),
    .grp_done        (d0_done),
    .sat_count_in    (dp2reg_sat_count),
    .reg_rd_data     (d0_rd_data),
    .op_en           (d0_op_en),
    .conv_mode       (d0_conv_mode),
    .proc_precision  (d0_proc_precision),
    .dataout_width   (d0_dataout_width),
    .dataout_height  (d0_dataout_height),
    .dataout_addr    (d0_dataout_addr)
  );

  cacc_dual_reg u_dual_reg_d1 (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_offset      (reg_offset),
    .reg_wr_data     (reg_wr_data),
    .reg_wr_en       (d1_wr_en),
    .grp_done        (d1_done),
    .sat_count_in    (dp2reg_sat_count),
    .reg_rd_data     (d1_rd_data),
    .op_en           (d1_op_en),
    .conv_mode       (d1_conv_mode),
    .proc_precision  (d1_proc_precision),
    .dataout_width   (d1_dataout_width),
    .dataout_height  (d1_dataout_height),
    .dataout_addr    (d1_dataout_addr)
  );

  cacc_group_ctrl u_group_ctrl (
    .nvdla_core_clk        (nvdla_core_clk),
    .nvdla_core_rstn       (nvdla_core_rstn),
    .dp2reg_done           (dp2reg_done),
    .reg_offset            (reg_offset),
    .reg_wr_en             (reg_wr_en),
    .producer              (producer),
    .s_rd_data             (s_rd_data),
    .d0_rd_data            (d0_rd_data),
    .d1_rd_data            (d1_rd_data),
    .d0_op_en              (d0_op_en),
    .d1_op_en              (d1_op_en),
    .d0_conv_mode          (d0_conv_mode),
    .d0_proc_precision     (d0_proc_precision),
    .d0_dataout_width      (d0_dataout_width),
    .d0_dataout_height     (d0_dataout_height),
    .d0_dataout_addr       (d0_dataout_addr),
    .d1_conv_mode          (d1_conv_mode),
    .d1_proc_precision     (d1_proc_precision),
    .d1_dataout_width      (d1_dataout_width),
    .d1_dataout_height     (d1_dataout_height),
    .d1_dataout_addr       (d1_dataout_addr),
    .s_wr_en               (s_wr_en),
    .d0_wr_en              (d0_wr_en),
    .d1_wr_en              (d1_wr_en),
    .d0_done               (d0_done),
    .d1_done               (d1_done),
    .consumer              (consumer),
    .status_0              (status_0),
    .status_1              (status_1),
    .reg_rd_data           (reg_rd_data),
    .reg2dp_op_en          (reg2dp_op_en),
    .reg2dp_conv_mode      (reg2dp_conv_mode),
    .reg2dp_proc_precision (reg2dp_proc_precision),
    .reg2dp_dataout_width  (reg2dp_dataout_width),
    .reg2dp_dataout_height (reg2dp_dataout_height),
    .reg2dp_dataout_addr   (reg2dp_dataout_addr)
  );

endmodule

`default_nettype wire

// File: cacc_group_ctrl.sv
/*
 * cacc group controller
 * consumer pointer, decode and write protect, read mux, status,
 * reg2dp output mux and the op_en delay line
 */
`default_nettype none
`include "cacc_consts.svh"

module cacc_group_ctrl (
  input  wire                         nvdla_core_clk,
  input  wire                         nvdla_core_rstn,
  input  wire                         dp2reg_done,
  input  wire  [`CACC_OFFS_W-1:0]     reg_offset,
  input  wire                         reg_wr_en,
  input  wire                         producer,
  input  wire  [`CACC_DATA_W-1:0]     s_rd_data,
  input  wire  [`CACC_DATA_W-1:0]     d0_rd_data,
  input  wire  [`CACC_DATA_W-1:0]     d1_rd_data,
  input  wire                         d0_op_en,
  input  wire                         d1_op_en,
  input  wire  cacc_reg_pkg::conv_mode_e d0_conv_mode,
  input  wire  cacc_reg_pkg::precision_e d0_proc_precision,
  input  wire  [`CACC_SIZE_W-1:0]     d0_dataout_width,
  input  wire  [`CACC_SIZE_W-1:0]     d0_dataout_height,
  input  wire  [`CACC_DATA_W-1:0]     d0_dataout_addr,
  input  wire  cacc_reg_pkg::conv_mode_e d1_conv_mode,
  input  wire  cacc_reg_pkg::precision_e d1_proc_precision,
  input  wire  [`CACC_SIZE_W-1:0]     d1_dataout_width,
  input  wire  [`CACC_SIZE_W-1:0]     d1_dataout_height,
  input  wire  [`CACC_DATA_W-1:0]     d1_dataout_addr,
  output logic                        s_wr_en,
  output logic                        d0_wr_en,
  output logic                        d1_wr_en,
  output logic                        d0_done,
  output logic                        d1_done,
  output logic                        consumer,
  output cacc_reg_pkg::group_status_e status_0,
  output cacc_reg_pkg::group_status_e status_1,
  output logic [`CACC_DATA_W-1:0]     reg_rd_data,
  output logic                        reg2dp_op_en,
  output cacc_reg_pkg::conv_mode_e    reg2dp_conv_mode,
  output cacc_reg_pkg::precision_e    reg2dp_proc_precision,
  output logic [`CACC_SIZE_W-1:0]     reg2dp_dataout_width,
  output logic [`CACC_SIZE_W-1:0]     reg2dp_dataout_height,
  output logic [`CACC_DATA_W-1:0]     reg2dp_dataout_addr
);
  import cacc_reg_pkg::*;

  logic                        select_s;
  logic                        select_d0;
  logic                        select_d1;
  logic                        op_en_ori;  // consumer's op_en, undelayed
  logic [`CACC_OPEN_DELAY-1:0] op_en_dly;

  //////////////////////////////
  // consumer pointer
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (dp2reg_done) begin
      consumer <= ~consumer;  // move on to the other group
    end
  end

  assign d0_done = dp2reg_done & ~consumer;
  assign d1_done = dp2reg_done & consumer;

  // decode, host writes into a busy group are dropped
  assign select_s  = reg_offset < `CACC_DUAL_BASE;
  assign select_d0 = ~select_s & ~producer;
  assign select_d1 = ~select_s & producer;
  assign s_wr_en   = reg_wr_en & select_s;
  assign d0_wr_en  = reg_wr_en & select_d0 & ~d0_op_en;
  assign d1_wr_en  = reg_wr_en & select_d1 & ~d1_op_en;

  assign reg_rd_data = ({`CACC_DATA_W{select_s}}  & s_rd_data) |
                       ({`CACC_DATA_W{select_d0}} & d0_rd_data) |
                       ({`CACC_DATA_W{select_d1}} & d1_rd_data);

  // group status
  assign status_0 = !d0_op_en ? GRP_IDLE : (!consumer ? GRP_RUNNING : GRP_PENDING);
  assign status_1 = !d1_op_en ? GRP_IDLE : (consumer ? GRP_RUNNING : GRP_PENDING);

  //////////////////////////////
  // reg2dp side
  //////////////////////////////
  always_comb begin
    if (consumer) begin
      reg2dp_conv_mode      = d1_conv_mode;
      reg2dp_proc_precision = d1_proc_precision;
      reg2dp_dataout_width  = d1_dataout_width;
      reg2dp_dataout_height = d1_dataout_height;
      reg2dp_dataout_addr   = d1_dataout_addr;
    end else begin
      reg2dp_conv_mode      = d0_conv_mode;
      reg2dp_proc_precision = d0_proc_precision;
      reg2dp_dataout_width  = d0_dataout_width;
      reg2dp_dataout_height = d0_dataout_height;
      reg2dp_dataout_addr   = d0_dataout_addr;
    end
  end

  assign op_en_ori = consumer ? d1_op_en : d0_op_en;

  // op_en delay line, flushed on done so the datapath sees a gap
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_dly <= '0;
    end else if (dp2reg_done) begin
      op_en_dly <= '0;
    end else begin
      op_en_dly <= {op_en_dly[`CACC_OPEN_DELAY-2:0], op_en_ori};
    end
  end

  assign reg2dp_op_en = op_en_dly[`CACC_OPEN_DELAY-1];

endmodule

`default_nettype wire

// File: cacc_dual_reg.sv
/*
 * one cacc ping-pong register group
 * config fields, op_en, sat_count capture and readback
 */
`default_nettype none
`include "cacc_consts.svh"

module cacc_dual_reg (
  input  wire                         nvdla_core_clk,
  input  wire                         nvdla_core_rstn,
  input  wire  [`CACC_OFFS_W-1:0]     reg_offset,
  input  wire  [`CACC_DATA_W-1:0]     reg_wr_data,
  input  wire                         reg_wr_en,
  input  wire                         grp_done,
  input  wire  [`CACC_DATA_W-1:0]     sat_count_in,
  output logic [`CACC_DATA_W-1:0]     reg_rd_data,
  output logic                        op_en,
  output cacc_reg_pkg::conv_mode_e    conv_mode,
  output cacc_reg_pkg::precision_e    proc_precision,
  output logic [`CACC_SIZE_W-1:0]     dataout_width,
  output logic [`CACC_SIZE_W-1:0]     dataout_height,
  output logic [`CACC_DATA_W-1:0]     dataout_addr
);
  import cacc_reg_pkg::*;

  logic                    wr_op_en;
  logic                    wr_misc;
  logic                    wr_size;
  logic                    wr_addr;
  logic                    op_en_w;     // next op_en
  logic                    op_en_fall;  // layer finished
  logic                    op_en_rise;  // layer armed
  logic [`CACC_DATA_W-1:0] sat_count;

  // write strobes, already gated by op_en upstream
  assign wr_op_en = reg_wr_en & (reg_offset == `CACC_OFFS_OP_ENABLE);
  assign wr_misc  = reg_wr_en & (reg_offset == `CACC_OFFS_MISC_CFG);
  assign wr_size  = reg_wr_en & (reg_offset == `CACC_OFFS_DATAOUT_SIZE);
  assign wr_addr  = reg_wr_en & (reg_offset == `CACC_OFFS_DATAOUT_ADDR);

  //////////////////////////////
  // config fields
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      conv_mode      <= CONV_DIRECT;
      proc_precision <= PREC_INT8;
      dataout_width  <= '0;
      dataout_height <= '0;
      dataout_addr   <= '0;
    end else begin
      if (wr_misc) begin
        conv_mode      <= conv_mode_e'(reg_wr_data[0]);
        proc_precision <= precision_e'(reg_wr_data[13:12]);
      end
      if (wr_size) begin
        dataout_width  <= reg_wr_data[`CACC_SIZE_W-1:0];
        dataout_height <= reg_wr_data[16 +: `CACC_SIZE_W];
      end
      if (wr_addr) begin
        dataout_addr <= reg_wr_data;
      end
    end
  end

  //////////////////////////////
  // op_en and sat_count
  //////////////////////////////
  always_comb begin
    op_en_w = op_en;
    if (wr_op_en) begin
      op_en_w = reg_wr_data[0];  // host write wins
    end else if (grp_done) begin
      op_en_w = 1'b0;
    end
  end

  assign op_en_fall = op_en & ~op_en_w;
  assign op_en_rise = ~op_en & op_en_w;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en     <= 1'b0;
      sat_count <= '0;
    end else begin
      op_en <= op_en_w;
      if (op_en_fall) begin
        sat_count <= sat_count_in;  // snapshot at end of layer
      end else if (op_en_rise) begin
        sat_count <= '0;
      end
    end
  end

  // readback
  always_comb begin
    reg_rd_data = '0;
    case (reg_offset)
      `CACC_OFFS_OP_ENABLE: reg_rd_data[0] = op_en;
      `CACC_OFFS_MISC_CFG: begin
        reg_rd_data[0]     = conv_mode;
        reg_rd_data[13:12] = proc_precision;
      end
      `CACC_OFFS_DATAOUT_SIZE: begin
        reg_rd_data[`CACC_SIZE_W-1:0]  = dataout_width;
        reg_rd_data[16 +: `CACC_SIZE_W] = dataout_height;
      end
      `CACC_OFFS_DATAOUT_ADDR: reg_rd_data = dataout_addr;
      `CACC_OFFS_SAT_COUNT:    reg_rd_data = sat_count;  // read only
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: cacc_single_reg.sv
/*
 * cacc single register group
 * producer pointer, pointer and status readback
 */
`default_nettype none
`include "cacc_consts.svh"

module cacc_single_reg (
  input  wire                         nvdla_core_clk,
  input  wire                         nvdla_core_rstn,
  input  wire  [`CACC_OFFS_W-1:0]     reg_offset,
  input  wire  [`CACC_DATA_W-1:0]     reg_wr_data,
  input  wire                         reg_wr_en,
  input  wire                         consumer,
  input  wire  cacc_reg_pkg::group_status_e status_0,
  input  wire  cacc_reg_pkg::group_status_e status_1,
  output logic [`CACC_DATA_W-1:0]     reg_rd_data,
  output logic                        producer
);

  // host flips producer to pick which group it programs
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (reg_wr_en && reg_offset == `CACC_OFFS_POINTER) begin
      producer <= reg_wr_data[0];
    end
  end

  // readback
  always_comb begin
    reg_rd_data = '0;  // unmapped offsets read 0
    case (reg_offset)
      `CACC_OFFS_POINTER: begin
        reg_rd_data[0]  = producer;
        reg_rd_data[16] = consumer;
      end
      `CACC_OFFS_STATUS: begin
        reg_rd_data[1:0]   = status_0;
        reg_rd_data[17:16] = status_1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: cacc_csb_bridge.sv
/*
 * csb slave side of the cacc register file
 * request register, unpacking, access strobes, response register
 */
`default_nettype none
`include "cacc_consts.svh"

module cacc_csb_bridge (
  input  wire                        nvdla_core_clk,
  input  wire                        nvdla_core_rstn,
  input  wire                        csb2cacc_req_pvld,
  input  wire  [`CACC_REQ_W-1:0]     csb2cacc_req_pd,
  input  wire  [`CACC_DATA_W-1:0]    reg_rd_data,
  output logic                       csb2cacc_req_prdy,
  output logic                       cacc2csb_resp_valid,
  output logic [`CACC_RESP_W-1:0]    cacc2csb_resp_pd,
  output logic [`CACC_OFFS_W-1:0]    reg_offset,
  output logic [`CACC_DATA_W-1:0]    reg_wr_data,
  output logic                       reg_wr_en,
  output logic                       reg_rd_en
);
  import csb_pkg::*;

  logic                        req_pvld;
  logic [`CACC_REQ_W-1:0]      req_pd;
  logic [`CACC_REQ_ADDR_W-1:0] req_addr;
  csb_kind_e                   req_kind;
  logic                        req_nposted;
  logic                        resp_en;
  csb_resp_kind_e              resp_kind;
  logic [`CACC_RESP_W-1:0]     resp_pd_w;

  assign csb2cacc_req_prdy = 1'b1;  // never stalls

  //////////////////////////////
  // request stage
  //////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_pvld <= 1'b0;
    end else begin
      req_pvld <= csb2cacc_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2cacc_req_pvld) begin
      req_pd <= csb2cacc_req_pd;  // only capture real requests
    end
  end

  // unpack, srcpriv/wrbe/level ignored
  assign req_addr    = req_pd[`CACC_REQ_ADDR_W-1:0];
  assign reg_wr_data = req_pd[`CACC_REQ_ADDR_W +: `CACC_DATA_W];
  assign req_kind    = csb_kind_e'(req_pd[`CACC_REQ_WRITE_BIT]);
  assign req_nposted = req_pd[`CACC_REQ_NPOSTED_BIT];

  // word address -> byte offset, upper bits dropped
  assign reg_offset = {req_addr[`CACC_OFFS_W-3:0], 2'b00};
  assign reg_wr_en  = req_pvld & (req_kind == CSB_WRITE);
  assign reg_rd_en  = req_pvld & (req_kind == CSB_READ);

  //////////////////////////////
  // response stage
  //////////////////////////////
  assign resp_en   = reg_rd_en | (reg_wr_en & req_nposted);  // posted writes stay silent
  assign resp_kind = reg_rd_en ? RESP_READ : RESP_WRITE;

  always_comb begin
    resp_pd_w = '0;  // error bit always 0
    resp_pd_w[`CACC_RESP_KIND_BIT] = resp_kind;
    if (reg_rd_en) begin
      resp_pd_w[`CACC_DATA_W-1:0] = reg_rd_data;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cacc2csb_resp_valid <= 1'b0;
    end else begin
      cacc2csb_resp_valid <= resp_en;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (resp_en) begin
      cacc2csb_resp_pd <= resp_pd_w;
    end
  end

endmodule

`default_nettype wire

// File: cacc_reg_pkg.sv
/*
 * cacc register field encodings
 * group status, processing precision, convolution mode
 */
`default_nettype none

package cacc_reg_pkg;

  // status of one ping-pong group as seen by the host
  typedef enum logic [1:0] {
    GRP_IDLE    = 2'd0,  // op_en clear
    GRP_RUNNING = 2'd1,  // being consumed
    GRP_PENDING = 2'd2   // armed, waiting for the other group
  } group_status_e;

  // misc_cfg bits 13:12
  typedef enum logic [1:0] {
    PREC_INT8  = 2'd0,
    PREC_INT16 = 2'd1,
    PREC_FP16  = 2'd2
  } precision_e;

  // misc_cfg bit 0
  typedef enum logic {
    CONV_DIRECT   = 1'b0,
    CONV_WINOGRAD = 1'b1
  } conv_mode_e;

endpackage

`default_nettype wire

// File: csb_pkg.sv
/*
 * csb request kind and response kind encodings
 */
`default_nettype none

package csb_pkg;

  // request bit 54
  typedef enum logic {
    CSB_READ  = 1'b0,
    CSB_WRITE = 1'b1
  } csb_kind_e;

  // response bit 33, which report the host gets back
  typedef enum logic {
    RESP_READ  = 1'b0,
    RESP_WRITE = 1'b1
  } csb_resp_kind_e;

endpackage

`default_nettype wire

// File: cacc_consts.svh
/*
 * cacc register file constants
 * csb packet widths and bit positions, register byte offsets
 */
`ifndef CACC_CONSTS_SVH
`define CACC_CONSTS_SVH

// csb packet and register widths
`define CACC_REQ_W 63
`define CACC_RESP_W 34
`define CACC_DATA_W 32
// word address carried in the request
`define CACC_REQ_ADDR_W 22
// byte offset inside the 4KB window
`define CACC_OFFS_W 12
`define CACC_SIZE_W 13

// request and response bit positions
`define CACC_REQ_WRITE_BIT 54
`define CACC_REQ_NPOSTED_BIT 55
`define CACC_RESP_KIND_BIT 33

// register byte offsets
`define CACC_OFFS_POINTER 12'h000
`define CACC_OFFS_STATUS 12'h004
`define CACC_OFFS_OP_ENABLE 12'h008
`define CACC_OFFS_MISC_CFG 12'h00c
`define CACC_OFFS_DATAOUT_SIZE 12'h010
`define CACC_OFFS_DATAOUT_ADDR 12'h014
`define CACC_OFFS_SAT_COUNT 12'h018

// everything from op_enable up lives in the ping-pong groups
`define CACC_DUAL_BASE `CACC_OFFS_OP_ENABLE
// reg2dp_op_en delay stages
`define CACC_OPEN_DELAY 3

`endif
